// ==== Makefile ====
SIM = obj_dir/branch_core_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f branch_core.f --top-module branch_core_tb \
		-Mdir obj_dir -o branch_core_sim

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== branch_core.f ====
+incdir+tb
source/la_isa_pkg.sv
source/core_pkg.sv
source/reg_file.sv
source/branch_unit.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_stage.sv
source/branch_core.sv
tb/branch_core_tb.sv

// ==== source/branch_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_core
    import core_pkg::*;
#(
    parameter int          IMEM_DEPTH = 64,
    parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          run,
    input  wire logic                          imem_we,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  wire logic [31:0]                   imem_wdata,
    output logic                               commit_valid,
    output commit_t                            commit_info
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .RESET_PC   (RESET_PC)
    ) u_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .if_id       (if_id)
    );

    decode_unit u_decode_unit (
        .clk      (clk),
        .reset    (reset),
        .if_id    (if_id),
        .redirect (redirect),
        .wb_we    (wb_we),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .id_ex    (id_ex)
    );

    execute_stage u_execute_stage (
        .clk          (clk),
        .reset        (reset),
        .id_ex        (id_ex),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .commit_valid (commit_valid),
        .commit_info  (commit_info)
    );

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import la_isa_pkg::*;
(
    input  wire br_type_t    br_type,
    input  wire logic [31:0] pc_orig, // pc of the branch itself
    input  wire logic [31:0] imm,
    input  wire logic [31:0] rj_val,
    input  wire logic [31:0] rk_val,
    output logic             br,
    output logic [31:0]      pc_br
);

    logic [31:0] pc_rel;
    logic        cond;

    assign pc_rel = pc_orig + imm;

    always_comb begin
        cond = 1'b0;
        unique case (br_type)
            BR_BEQ:  cond = (rj_val == rk_val);
            BR_BNE:  cond = (rj_val != rk_val);
            BR_BLT:  cond = ($signed(rj_val) < $signed(rk_val));
            BR_BGE:  cond = ($signed(rj_val) >= $signed(rk_val));
            BR_BLTU: cond = (rj_val < rk_val);
            BR_BGEU: cond = (rj_val >= rk_val);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        br    = 1'b0;
        pc_br = 32'd0; // Zero unless taken
        case (br_type)
            BR_JIRL: begin
                br    = 1'b1;
                pc_br = rj_val + imm; // Register indirect
            end
            BR_B, BR_BL: begin
                br    = 1'b1;
                pc_br = pc_rel;
            end
            BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU: begin
                if (cond) begin
                    br    = 1'b1;
                    pc_br = pc_rel;
                end
            end
            default: begin
                br = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

    import la_isa_pkg::*;

    // Writeback result select
    localparam logic [1:0] RES_ADD  = 2'd0; // rj + imm
    localparam logic [1:0] RES_OR   = 2'd1; // rj | imm
    localparam logic [1:0] RES_IMM  = 2'd2; // imm as is
    localparam logic [1:0] RES_LINK = 2'd3; // pc + 4

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        br_type_t    br_type;
        logic [31:0] imm;
        logic [31:0] rj_val;
        logic [31:0] rk_val;
        logic [4:0]  rd; // Destination index
        logic        we;
        logic [1:0]  res_sel;
    } id_ex_t;

    // Retire record
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        we;
        logic        br;
        logic [31:0] target;
    } commit_t;

endpackage

`default_nettype wire

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit
    import la_isa_pkg::*;
    import core_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire if_id_t      if_id,
    input  wire logic        redirect,
    input  wire logic        wb_we,
    input  wire logic [4:0]  wb_addr,
    input  wire logic [31:0] wb_data,
    output id_ex_t           id_ex
);

    instr_u      iw;
    logic [31:0] raw;
    logic        is_br;
    logic [31:0] rd1;
    logic [31:0] rd2;
    id_ex_t      id_ex_d;

    assign iw  = if_id.instr;
    assign raw = if_id.instr;

    // Branch group with codes 3 to 11 only
    assign is_br = (iw.r16.opcode[5:4] == OP_BR_MAJOR[5:4])
                && (iw.r16.opcode[3:0] inside {[4'd3:4'd11]});

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .ra1   (iw.r16.rj),
        .ra2   (iw.r16.rd), // Conditional branches compare rj with rd
        .we    (wb_we),
        .wa    (wb_addr),
        .wd    (wb_data),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_id.valid;
        id_ex_d.pc      = if_id.pc;
        id_ex_d.instr   = if_id.instr;
        id_ex_d.br_type = BR_NONE;
        id_ex_d.rj_val  = rd1;
        id_ex_d.rk_val  = rd2;
        id_ex_d.rd      = iw.r16.rd;
        id_ex_d.res_sel = RES_ADD;

        if (is_br) begin
            id_ex_d.br_type = br_type_t'(iw.r16.opcode[3:0]);
            if (id_ex_d.br_type inside {BR_B, BR_BL}) begin
                id_ex_d.imm = {{4{iw.i26.offs_hi[9]}}, iw.i26.offs_hi, iw.i26.offs_lo, 2'b00};
            end else begin
                id_ex_d.imm = {{14{iw.r16.offs16[15]}}, iw.r16.offs16, 2'b00};
            end
            if (id_ex_d.br_type == BR_JIRL) begin
                id_ex_d.we      = 1'b1;
                id_ex_d.res_sel = RES_LINK;
            end else if (id_ex_d.br_type == BR_BL) begin
                id_ex_d.we      = 1'b1;
                id_ex_d.res_sel = RES_LINK;
                id_ex_d.rd      = 5'd1; // Link register
            end
        end else if (raw[31:22] == OP_ADDI_W) begin
            id_ex_d.imm = {{20{raw[21]}}, raw[21:10]};
            id_ex_d.we  = 1'b1;
        end else if (raw[31:22] == OP_ORI) begin
            id_ex_d.imm     = {20'd0, raw[21:10]}; // Zero extended
            id_ex_d.we      = 1'b1;
            id_ex_d.res_sel = RES_OR;
        end else if (raw[31:25] == OP_LU12I_W) begin
            id_ex_d.imm     = {raw[24:5], 12'd0};
            id_ex_d.we      = 1'b1;
            id_ex_d.res_sel = RES_IMM;
        end
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (reset || redirect) begin
            id_ex.valid <= 1'b0; // Bubble behind a taken branch
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire id_ex_t id_ex,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        wb_we,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data,
    output logic        commit_valid,
    output commit_t     commit_info
);

    logic        br;
    logic [31:0] pc_br;
    logic [31:0] result;

    branch_unit u_branch_unit (
        .br_type (id_ex.br_type),
        .pc_orig (id_ex.pc),
        .imm     (id_ex.imm),
        .rj_val  (id_ex.rj_val),
        .rk_val  (id_ex.rk_val),
        .br      (br),
        .pc_br   (pc_br)
    );

    always_comb begin
        unique case (id_ex.res_sel)
            RES_ADD:  result = id_ex.rj_val + id_ex.imm; // ADDI.W
            RES_OR:   result = id_ex.rj_val | id_ex.imm; // ORI
            RES_IMM:  result = id_ex.imm; // LU12I.W
            default:  result = id_ex.pc + 32'd4; // Link for JIRL and BL
        endcase
    end

    assign wb_we       = id_ex.valid && id_ex.we;
    assign wb_addr     = id_ex.rd;
    assign wb_data     = result;
    assign redirect    = id_ex.valid && br;
    assign redirect_pc = pc_br;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= id_ex.valid; // One strobe per retired word
        end
        commit_info.pc     <= id_ex.pc;
        commit_info.rd     <= id_ex.rd;
        commit_info.wdata  <= result;
        commit_info.we     <= id_ex.we;
        commit_info.br     <= br;
        commit_info.target <= pc_br;
    end

    // A taken branch leaves exactly two bubbles behind it
    a_redirect_bubbles: assert property (@(posedge clk) disable iff (reset)
        redirect |-> id_ex.valid ##1 !id_ex.valid ##1 !id_ex.valid);

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import core_pkg::*;
#(
    parameter int          IMEM_DEPTH = 64,
    parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          run,
    input  wire logic                          imem_we,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  wire logic [31:0]                   imem_wdata,
    input  wire logic                          redirect,
    input  wire logic [31:0]                   redirect_pc,
    output if_id_t                             if_id
);

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [31:0] imem [IMEM_DEPTH];
    logic [31:0] pc;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata; // Loader port, run low only
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc; // Taken branch from execute
        end else if (run) begin
            pc <= pc + 32'd4; // Predict not taken
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            if_id.valid <= 1'b0; // Squash wrong-path word
        end else begin
            if_id.valid <= run;
        end
        if_id.pc    <= pc;
        if_id.instr <= imem[pc[AW+1:2]]; // Word address
    end

    // Loader and fetch never share the memory
    a_no_load_while_run: assert property (@(posedge clk) disable iff (reset) run |-> !imem_we);

endmodule

`default_nettype wire

// ==== source/la_isa_pkg.sv ====
`default_nettype none

package la_isa_pkg;

    // Branch class, equal to instruction bits 29:26
    typedef enum logic [3:0] {
        BR_NONE = 4'b0000,
        BR_JIRL = 4'b0011,
        BR_B    = 4'b0100,
        BR_BL   = 4'b0101,
        BR_BEQ  = 4'b0110,
        BR_BNE  = 4'b0111,
        BR_BLT  = 4'b1000,
        BR_BGE  = 4'b1001,
        BR_BLTU = 4'b1010,
        BR_BGEU = 4'b1011
    } br_type_t;

    localparam logic [5:0] OP_BR_MAJOR = 6'b010000; // Bits 31:30 mark the branch group
    localparam logic [9:0] OP_ADDI_W   = 10'b0000001010; // Bits 31:22
    localparam logic [9:0] OP_ORI      = 10'b0000001110; // Bits 31:22
    localparam logic [6:0] OP_LU12I_W  = 7'b0001010; // Bits 31:25

    // 2RI16 form used by JIRL and the conditional branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    // I26 form used by B and BL, offset high part sits in the low bits
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_2ri16_t r16;
        fmt_i26_t   i26;
    } instr_u;

endpackage

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  ra1,
    input  wire logic [4:0]  ra2,
    input  wire logic        we,
    input  wire logic [4:0]  wa,
    input  wire logic [31:0] wd,
    output logic      [31:0] rd1,
    output logic      [31:0] rd2
);

    logic [31:0] regs [32];

    // One read port, with bypass of the write in flight
    function automatic logic [31:0] read_port(input logic [4:0] ra);
        if (ra == 5'd0) begin
            return 32'd0;
        end else if (we && (wa == ra)) begin
            return wd; // Execute writes this cycle
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd; // r0 never written
        end
    end

    assign rd1 = read_port(ra1);
    assign rd2 = read_port(ra2);

endmodule

`default_nettype wire

// ==== tb/branch_cases.svh ====
`ifndef BRANCH_CASES_SVH
`define BRANCH_CASES_SVH

// Columns: branch type, rj operand (r4), rd operand (r5), byte offset, expected taken
typedef struct packed {
    br_type_t    kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] off;
    logic        taken;
} br_case_t;

localparam int NUM_TABLE_CASES = 23;

localparam br_case_t CASE_TABLE [NUM_TABLE_CASES] = '{
    '{BR_BEQ,  32'h1234_5678, 32'h1234_5678, 32'h0000_0020, 1'b1},
    '{BR_BEQ,  32'h1234_5678, 32'h1234_5679, 32'h0000_0020, 1'b0},
    '{BR_BNE,  32'h0000_0005, 32'h0000_0005, 32'hffff_ffb8, 1'b0},
    '{BR_BNE,  32'h0000_0005, 32'h8000_0005, 32'hffff_ffb8, 1'b1},
    '{BR_BLT,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0030, 1'b1}, // -1 < 1 signed
    '{BR_BLT,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0030, 1'b0},
    '{BR_BLT,  32'h7fff_ffff, 32'h7fff_ffff, 32'h0000_0030, 1'b0},
    '{BR_BGE,  32'h0000_0001, 32'hffff_ffff, 32'hffff_ffa0, 1'b1},
    '{BR_BGE,  32'h8000_0000, 32'h0000_0000, 32'hffff_ffa0, 1'b0},
    '{BR_BGE,  32'hdead_beef, 32'hdead_beef, 32'hffff_ffa0, 1'b1},
    '{BR_BLTU, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0064, 1'b1}, // Last memory word
    '{BR_BLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0064, 1'b0},
    '{BR_BGEU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0008, 1'b1},
    '{BR_BGEU, 32'h0000_0000, 32'h8000_0000, 32'h0000_0008, 1'b0},
    '{BR_BGEU, 32'h0000_abcd, 32'h0000_abcd, 32'h0000_0008, 1'b1},
    '{BR_B,    32'h0000_0000, 32'h0000_0000, 32'hffff_ff68, 1'b1}, // Back to address 0
    '{BR_B,    32'h0000_0000, 32'h0000_0000, 32'h0000_0040, 1'b1},
    '{BR_B,    32'h0000_0000, 32'h0000_0000, 32'h0004_0040, 1'b1}, // Uses the high offset field
    '{BR_BL,   32'h0000_0000, 32'h0000_0000, 32'hffff_ff70, 1'b1},
    '{BR_BL,   32'h0000_0000, 32'h0000_0000, 32'h0000_0028, 1'b1},
    '{BR_BL,   32'h0000_0000, 32'h0000_0000, 32'hfff0_0008, 1'b1},
    '{BR_JIRL, 32'h0000_0040, 32'h0000_0000, 32'h0000_0010, 1'b1},
    '{BR_JIRL, 32'h0000_00f0, 32'h0000_0000, 32'hffff_fff4, 1'b1}
};

`endif

// ==== tb/branch_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_core_tb
    import la_isa_pkg::*;
    import core_pkg::*;
();

`include "branch_cases.svh"

    localparam int          IMEM_DEPTH  = 64;
    localparam logic [31:0] RESET_PC    = 32'h0000_0080;
    localparam logic [31:0] BR_PC       = RESET_PC + 32'h18;
    localparam logic [31:0] FALL_PC     = BR_PC + 32'd4;
    localparam logic [11:0] R0_IMM      = 12'h123;
    localparam logic [11:0] R3_IMM      = 12'h05a;
    localparam logic [11:0] FALL_MARK   = 12'h0f1;
    localparam logic [11:0] TGT_MARK    = 12'h0a5;
    localparam int          NUM_COMMITS = 8; // Six setup words, branch, marker
    localparam int          WAIT_CYCLES = 40;
    localparam int          NUM_LFSR    = 12;
    localparam int          CASE_CYCLES = IMEM_DEPTH + WAIT_CYCLES + 8;
    localparam int          WATCHDOG_NS = ((NUM_TABLE_CASES + NUM_LFSR) * CASE_CYCLES + 50) * 4;

    logic        clk;
    logic        reset;
    logic        run;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic        commit_valid;
    commit_t     commit_info;

    int          errors = 0;
    int          checks = 0;
    int          case_errors = 0;
    int          cycle = 0;
    commit_t     seen_info [$];
    int          seen_cycle [$];
    logic [31:0] lfsr = 32'hdb0b_3575;

    branch_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .RESET_PC   (RESET_PC)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .commit_valid (commit_valid),
        .commit_info  (commit_info)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        if (commit_valid) begin
            seen_info.push_back(commit_info); // Registered outputs, stable here
            seen_cycle.push_back(cycle);
        end
    end

    function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd}; // ADDI.W and ORI share this layout
    endfunction

    function automatic logic [31:0] enc_branch(input br_type_t kind, input logic [31:0] off);
        if (kind == BR_B || kind == BR_BL) begin
            return {2'b01, kind, off[17:2], off[27:18]};
        end
        return {2'b01, kind, off[17:2], 5'd4, (kind == BR_JIRL) ? 5'd9 : 5'd5};
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[7:2]);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
    endfunction

    function automatic logic cond_taken(input br_type_t kind, input logic [31:0] a,
                                        input logic [31:0] b);
        case (kind)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
            case_errors++;
        end
    endtask

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic make_lfsr_case(output br_case_t c);
        logic [31:0] r;
        take_bits(3, r);
        c.kind = br_type_t'(4'd6 + 4'(r % 32'd6)); // BEQ through BGEU
        take_bits(32, r);
        c.a = r;
        take_bits(32, r);
        c.b = r;
        take_bits(2, r);
        if (r[1:0] == 2'b11) c.b = c.a; // Equal operands now and then
        take_bits(4, r);
        c.off   = (32'(r[3:0]) + 32'd2) << 2; // Lands past the fall-through word
        c.taken = cond_taken(c.kind, c.a, c.b);
    endtask

    task automatic load_program(input br_case_t c, input logic [31:0] tgt);
        logic [31:0] prog [IMEM_DEPTH];
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = {16'hffff, 10'd0, 6'(i)}; // Unknown opcode, retires as no-op
        end
        prog[word_index(RESET_PC)]      = enc_i12(10'b0000001010, 5'd0, 5'd0, R0_IMM);
        prog[word_index(RESET_PC + 4)]  = enc_i12(10'b0000001010, 5'd3, 5'd0, R3_IMM);
        prog[word_index(RESET_PC + 8)]  = {7'b0001010, c.a[31:12], 5'd4};
        prog[word_index(RESET_PC + 12)] = enc_i12(10'b0000001110, 5'd4, 5'd4, c.a[11:0]);
        prog[word_index(RESET_PC + 16)] = {7'b0001010, c.b[31:12], 5'd5};
        prog[word_index(RESET_PC + 20)] = enc_i12(10'b0000001110, 5'd5, 5'd5, c.b[11:0]);
        prog[word_index(BR_PC)]         = enc_branch(c.kind, c.off);
        prog[word_index(FALL_PC)]       = enc_i12(10'b0000001010, 5'd6, 5'd0, FALL_MARK);
        if (c.taken) prog[word_index(tgt)] = enc_i12(10'b0000001010, 5'd7, 5'd0, TGT_MARK);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= 6'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic run_case(input int idx, input br_case_t c);
        logic [31:0] tgt;
        logic        link;
        int          waited;
        case_errors = 0;
        link = (c.kind == BR_JIRL) || (c.kind == BR_BL);
        if (!c.taken) tgt = 32'd0;
        else if (c.kind == BR_JIRL) tgt = c.a + c.off;
        else tgt = BR_PC + c.off;
        @(posedge clk);
        reset <= 1'b1;
        run   <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        load_program(c, tgt);
        seen_info.delete();
        seen_cycle.delete();
        run    <= 1'b1;
        waited = 0;
        while (seen_info.size() < NUM_COMMITS && waited < WAIT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        run <= 1'b0;
        if (seen_info.size() < NUM_COMMITS) begin
            $display("Case %0d stalled with %0d of %0d commits after %0d cycles",
                     idx, seen_info.size(), NUM_COMMITS, WAIT_CYCLES);
            errors++;
            case_errors++;
        end else begin
            for (int i = 0; i < 7; i++) begin
                check_eq("commit_info.pc", seen_info[i].pc, RESET_PC + 32'(4 * i));
            end
            check_eq("commit_info.wdata r3", seen_info[1].wdata, {20'd0, R3_IMM}); // r0 bypass
            check_eq("commit_info.wdata r4 hi", seen_info[2].wdata, {c.a[31:12], 12'd0});
            check_eq("commit_info.wdata r4", seen_info[3].wdata, c.a);
            check_eq("commit_info.wdata r5 hi", seen_info[4].wdata, {c.b[31:12], 12'd0});
            check_eq("commit_info.wdata r5", seen_info[5].wdata, c.b);
            check_eq("commit_info.br", 32'(seen_info[6].br), 32'(c.taken));
            check_eq("commit_info.target", seen_info[6].target, tgt);
            check_eq("commit_info.we", 32'(seen_info[6].we), 32'(link));
            if (link) begin
                check_eq("commit_info.rd link", 32'(seen_info[6].rd),
                         (c.kind == BR_BL) ? 32'd1 : 32'd9);
                check_eq("commit_info.wdata link", seen_info[6].wdata, BR_PC + 32'd4);
            end
            check_eq("next commit_info.pc", seen_info[7].pc, c.taken ? tgt : FALL_PC);
            check_eq("next commit_info.rd", 32'(seen_info[7].rd), c.taken ? 32'd7 : 32'd6);
            check_eq("next commit_info.wdata", seen_info[7].wdata,
                     {20'd0, c.taken ? TGT_MARK : FALL_MARK});
            check_eq("idle cycles", 32'(seen_cycle[7] - seen_cycle[6] - 1),
                     c.taken ? 32'd2 : 32'd0);
        end
        $display("Case %0d %s a=%h b=%h off=%h %s: %s", idx, c.kind.name(), c.a, c.b, c.off,
                 c.taken ? "taken" : "not taken", (case_errors == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        br_case_t lc;
        $timeformat(-9, 0, " ns", 0);
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        for (int i = 0; i < NUM_TABLE_CASES; i++) begin
            run_case(i, CASE_TABLE[i]);
        end
        for (int i = 0; i < NUM_LFSR; i++) begin
            make_lfsr_case(lc);
            run_case(NUM_TABLE_CASES + i, lc);
        end
        $display("%0d cases, %0d checks, %0d errors", NUM_TABLE_CASES + NUM_LFSR, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
